// File: soc_pkg.sv
package soc_pkg;

  localparam int unsigned xlen = 32;
  localparam int unsigned strb_width = xlen / 8;

  // Address map
  localparam logic [xlen-1:0] rom_base_addr = 32'h0000_0000;
  localparam logic [xlen-1:0] rom_top_addr = 32'h0000_0040;
  localparam logic [xlen-1:0] clint_base_addr = 32'h0200_0000;
  localparam logic [xlen-1:0] clint_top_addr = 32'h0201_0000;

  // CLINT register offsets, relative to clint_base_addr
  localparam int unsigned clint_off_width = 16;
  localparam logic [clint_off_width-1:0] clint_msip_off = 16'h0000;
  localparam logic [clint_off_width-1:0] clint_mtimecmp_lo_off = 16'h4000;
  localparam logic [clint_off_width-1:0] clint_mtimecmp_hi_off = 16'h4004;
  localparam logic [clint_off_width-1:0] clint_mtime_lo_off = 16'hBFF8;
  localparam logic [clint_off_width-1:0] clint_mtime_hi_off = 16'hBFFC;

endpackage

// File: mem_bus_if.sv
interface mem_bus_if;
  import soc_pkg::*;

  logic valid;
  logic instr;
  logic [xlen-1:0] addr;
  logic [xlen-1:0] wdata;
  logic [strb_width-1:0] wstrb;
  logic [xlen-1:0] rdata;
  logic ready;

  // Decoder side
  modport requester (
    output valid, instr, addr, wdata, wstrb,
    input rdata, ready
  );

  // Slave side
  modport responder (
    input valid, instr, addr, wdata, wstrb,
    output rdata, ready
  );

endinterface

// File: bus_decoder.sv
module bus_decoder #(
  parameter int unsigned rom_words = 16
) (
  input  logic clock,
  input  logic reset,
  input  logic mem_valid_i,
  input  logic mem_instr_i,
  input  logic [soc_pkg::xlen-1:0] mem_addr_i,
  input  logic [soc_pkg::xlen-1:0] mem_wdata_i,
  input  logic [soc_pkg::strb_width-1:0] mem_wstrb_i,
  output logic [soc_pkg::xlen-1:0] mem_rdata_o,
  output logic mem_error_o,
  output logic mem_ready_o,
  mem_bus_if.requester rom_bus,
  mem_bus_if.requester clint_bus
);
  import soc_pkg::*;

  // ROM window shrinks to the populated depth, never past rom_top_addr
  localparam logic [xlen-1:0] rom_span = xlen'(rom_words * strb_width);
  localparam logic [xlen-1:0] rom_end_addr =
    (rom_span < rom_top_addr - rom_base_addr) ? rom_base_addr + rom_span : rom_top_addr;

  logic rom_hit;
  logic clint_hit;
  logic req_error;
  logic error_q;
  logic [xlen-1:0] base_addr;

  always_comb begin
    rom_hit = (mem_addr_i >= rom_base_addr) && (mem_addr_i < rom_end_addr);
    // No instruction fetch from timer space
    clint_hit = (mem_addr_i >= clint_base_addr) && (mem_addr_i < clint_top_addr) &&
                !mem_instr_i;
    req_error = mem_valid_i && !rom_hit && !clint_hit;

    if (rom_hit) begin
      base_addr = rom_base_addr;
    end else if (clint_hit) begin
      base_addr = clint_base_addr;
    end else begin
      base_addr = '0;
    end
  end

  assign rom_bus.valid = mem_valid_i && rom_hit;
  assign rom_bus.instr = mem_instr_i;
  assign rom_bus.addr = mem_addr_i - base_addr;
  assign rom_bus.wdata = mem_wdata_i;
  assign rom_bus.wstrb = mem_wstrb_i;

  assign clint_bus.valid = mem_valid_i && clint_hit;
  assign clint_bus.instr = mem_instr_i;
  assign clint_bus.addr = mem_addr_i - base_addr;
  assign clint_bus.wdata = mem_wdata_i;
  assign clint_bus.wstrb = mem_wstrb_i;

  // Error answers one cycle later, like a slave would
  always_ff @(posedge clock) begin
    if (!reset) begin
      error_q <= 1'b0;
    end else begin
      error_q <= req_error;
    end
  end

  always_comb begin
    if (rom_bus.ready) begin
      mem_rdata_o = rom_bus.rdata;
      mem_error_o = 1'b0;
      mem_ready_o = 1'b1;
    end else if (clint_bus.ready) begin
      mem_rdata_o = clint_bus.rdata;
      mem_error_o = 1'b0;
      mem_ready_o = 1'b1;
    end else if (error_q) begin
      mem_rdata_o = '0;
      mem_error_o = 1'b1;
      mem_ready_o = 1'b1;
    end else begin
      mem_rdata_o = '0;
      mem_error_o = 1'b0;
      mem_ready_o = 1'b0;
    end
  end

endmodule

// File: boot_rom.sv
module boot_rom #(
  parameter int unsigned rom_words = 16
) (
  input logic clock,
  input logic reset,
  mem_bus_if.responder bus
);
  import soc_pkg::*;

  localparam int unsigned index_width = (rom_words > 1) ? $clog2(rom_words) : 1;

  logic [xlen-1:0] rom_mem [rom_words];
  logic [xlen-1:0] rdata_q;
  logic ready_q;
  logic [index_width-1:0] word_index;

  initial begin
    $readmemh("boot_rom.hex", rom_mem);
  end

  assign word_index = bus.addr[index_width+1:2]; // Drop the byte offset

  always_ff @(posedge clock) begin
    if (!reset) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= bus.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (bus.valid) begin
      rdata_q <= (bus.wstrb != '0) ? '0 : rom_mem[word_index]; // Writes are dropped
    end
  end

  assign bus.rdata = rdata_q;
  assign bus.ready = ready_q;

endmodule

// File: clint_timer.sv
module clint_timer (
  input  logic clock,
  input  logic reset,
  mem_bus_if.responder bus,
  output logic msip_o,
  output logic mtip_o
);
  import soc_pkg::*;

  logic [63:0] mtime;
  logic [63:0] mtimecmp;
  logic msip;
  logic mtip_q;
  logic wr_en;
  logic [clint_off_width-1:0] offset;
  logic [xlen-1:0] rd_data;
  logic [xlen-1:0] rdata_q;
  logic ready_q;

  // Replace only the byte lanes selected by strb
  function automatic logic [xlen-1:0] merge_bytes(
    input logic [xlen-1:0] old_word,
    input logic [xlen-1:0] new_word,
    input logic [strb_width-1:0] strb
  );
    logic [xlen-1:0] result;
    result = old_word;
    for (int i = 0; i < strb_width; i++) begin
      if (strb[i]) begin
        result[i*8 +: 8] = new_word[i*8 +: 8];
      end
    end
    return result;
  endfunction

  assign offset = bus.addr[clint_off_width-1:0];
  assign wr_en = bus.valid && (bus.wstrb != '0);

  always_comb begin
    case (offset)
      clint_msip_off:        rd_data = {{(xlen-1){1'b0}}, msip};
      clint_mtimecmp_lo_off: rd_data = mtimecmp[31:0];
      clint_mtimecmp_hi_off: rd_data = mtimecmp[63:32];
      clint_mtime_lo_off:    rd_data = mtime[31:0];
      clint_mtime_hi_off:    rd_data = mtime[63:32];
      default:               rd_data = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      mtime <= '0;
      mtimecmp <= '1;
      msip <= 1'b0;
      mtip_q <= 1'b0;
      ready_q <= 1'b0;
    end else begin
      mtime <= mtime + 64'd1;
      mtip_q <= (mtime >= mtimecmp); // Compare of the previous cycle
      ready_q <= bus.valid;
      if (wr_en) begin
        case (offset)
          clint_msip_off: begin
            if (bus.wstrb[0]) begin
              msip <= bus.wdata[0];
            end
          end
          clint_mtimecmp_lo_off: begin
            mtimecmp[31:0] <= merge_bytes(mtimecmp[31:0], bus.wdata, bus.wstrb);
          end
          clint_mtimecmp_hi_off: begin
            mtimecmp[63:32] <= merge_bytes(mtimecmp[63:32], bus.wdata, bus.wstrb);
          end
          default: begin
          end
        endcase
      end
    end
  end

  // Read data sampled in the request cycle
  always_ff @(posedge clock) begin
    if (bus.valid) begin
      rdata_q <= wr_en ? '0 : rd_data;
    end
  end

  assign bus.rdata = rdata_q;
  assign bus.ready = ready_q;
  assign msip_o = msip;
  assign mtip_o = mtip_q;

endmodule

// File: soc_bus.sv
module soc_bus #(
  parameter int unsigned rom_words = 16
) (
  input  logic clock,
  input  logic reset,
  input  logic mem_valid_i,
  input  logic mem_instr_i,
  input  logic [soc_pkg::xlen-1:0] mem_addr_i,
  input  logic [soc_pkg::xlen-1:0] mem_wdata_i,
  input  logic [soc_pkg::strb_width-1:0] mem_wstrb_i,
  output logic [soc_pkg::xlen-1:0] mem_rdata_o,
  output logic mem_error_o,
  output logic mem_ready_o,
  output logic msip_o,
  output logic mtip_o
);

  mem_bus_if rom_bus ();
  mem_bus_if clint_bus ();

  bus_decoder #(
    .rom_words(rom_words)
  ) u_bus_decoder (
    .clock(clock),
    .reset(reset),
    .mem_valid_i(mem_valid_i),
    .mem_instr_i(mem_instr_i),
    .mem_addr_i(mem_addr_i),
    .mem_wdata_i(mem_wdata_i),
    .mem_wstrb_i(mem_wstrb_i),
    .mem_rdata_o(mem_rdata_o),
    .mem_error_o(mem_error_o),
    .mem_ready_o(mem_ready_o),
    .rom_bus(rom_bus.requester),
    .clint_bus(clint_bus.requester)
  );

  boot_rom #(
    .rom_words(rom_words)
  ) u_boot_rom (
    .clock(clock),
    .reset(reset),
    .bus(rom_bus.responder)
  );

  clint_timer u_clint_timer (
    .clock(clock),
    .reset(reset),
    .bus(clint_bus.responder),
    .msip_o(msip_o),
    .mtip_o(mtip_o)
  );

endmodule

// File: tb_clock_gen.sv
module tb_clock_gen (
  output logic clock,
  output logic reset
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock; // 8 ns period
  end

  initial begin
    reset = 1'b0;
    repeat (3) @(posedge clock);
    reset <= 1'b1;
  end

endmodule

// File: tb_soc_bus.sv
module tb_soc_bus;
  timeunit 1ns;
  timeprecision 100ps;
  import soc_pkg::*;

  localparam int unsigned rom_words = 16;
  localparam int rom_index_bits = $clog2(rom_words);
  localparam int test_cycles = 140;
  localparam int margin_cycles = 100;

  logic clock;
  logic reset;
  logic mem_valid_i;
  logic mem_instr_i;
  logic [xlen-1:0] mem_addr_i;
  logic [xlen-1:0] mem_wdata_i;
  logic [strb_width-1:0] mem_wstrb_i;
  logic [xlen-1:0] mem_rdata_o;
  logic mem_error_o;
  logic mem_ready_o;
  logic msip_o;
  logic mtip_o;

  logic [xlen-1:0] rom_model [rom_words];
  logic msip_model;
  logic [63:0] cmp_model;
  logic [63:0] cycle_count;
  logic [63:0] last_mtime;
  int edge_count;
  logic [xlen-1:0] exp_rdata_q [$];
  logic exp_error_q [$];
  int exp_due_q [$];

  tb_clock_gen u_clock_gen (
    .clock(clock),
    .reset(reset)
  );

  soc_bus #(
    .rom_words(rom_words)
  ) DUT (
    .clock(clock),
    .reset(reset),
    .mem_valid_i(mem_valid_i),
    .mem_instr_i(mem_instr_i),
    .mem_addr_i(mem_addr_i),
    .mem_wdata_i(mem_wdata_i),
    .mem_wstrb_i(mem_wstrb_i),
    .mem_rdata_o(mem_rdata_o),
    .mem_error_o(mem_error_o),
    .mem_ready_o(mem_ready_o),
    .msip_o(msip_o),
    .mtip_o(mtip_o)
  );

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [xlen-1:0] actual,
                             input logic [xlen-1:0] expected);
    if (actual !== expected) begin
      stop_on_error($sformatf("MISMATCH at %0d ns: %s is %h, expected %h",
                              $time, name, actual, expected));
    end
  endtask

  function automatic logic [xlen-1:0] clint_addr(input logic [clint_off_width-1:0] off);
    return clint_base_addr + 32'(off);
  endfunction

  // Selected lanes come from the new word, the rest keep the old bytes
  function automatic logic [xlen-1:0] byte_merge(input logic [xlen-1:0] old_word,
                                                 input logic [xlen-1:0] new_word,
                                                 input logic [strb_width-1:0] strb);
    logic [xlen-1:0] lane_mask;
    for (int i = 0; i < strb_width; i++) begin
      lane_mask[i*8 +: 8] = {8{strb[i]}};
    end
    return (old_word & ~lane_mask) | (new_word & lane_mask);
  endfunction

  // Returns {error, rdata} and updates the CLINT register model on writes
  function automatic logic [xlen:0] predict_response(input logic instr,
                                                     input logic [xlen-1:0] addr,
                                                     input logic [xlen-1:0] wdata,
                                                     input logic [strb_width-1:0] wstrb,
                                                     input logic [63:0] mtime_now);
    logic in_rom;
    logic in_clint;
    logic err;
    logic [clint_off_width-1:0] offset;
    logic [rom_index_bits-1:0] rom_index;
    logic [xlen-1:0] rdata;
    in_rom = (addr - rom_base_addr) < 32'(rom_words * strb_width);
    in_clint = (addr - clint_base_addr) < (clint_top_addr - clint_base_addr);
    offset = clint_off_width'(addr - clint_base_addr);
    rom_index = addr[rom_index_bits+1:2];
    rdata = '0;
    err = 1'b0;
    if (in_rom) begin
      if (wstrb == '0) begin
        rdata = rom_model[rom_index];
      end
    end else if (in_clint && !instr) begin
      if (wstrb != '0) begin
        case (offset)
          clint_msip_off: begin
            if (wstrb[0]) begin
              msip_model = wdata[0];
            end
          end
          clint_mtimecmp_lo_off: cmp_model[31:0] = byte_merge(cmp_model[31:0], wdata, wstrb);
          clint_mtimecmp_hi_off: cmp_model[63:32] = byte_merge(cmp_model[63:32], wdata, wstrb);
          default: begin
          end
        endcase
      end else begin
        case (offset)
          clint_msip_off:        rdata = {31'h0, msip_model};
          clint_mtimecmp_lo_off: rdata = cmp_model[31:0];
          clint_mtimecmp_hi_off: rdata = cmp_model[63:32];
          clint_mtime_lo_off:    rdata = mtime_now[31:0];
          clint_mtime_hi_off:    rdata = mtime_now[63:32];
          default:               rdata = '0;
        endcase
      end
    end else begin
      err = 1'b1; // Unmapped, or a fetch from timer space
    end
    return {err, rdata};
  endfunction

  task automatic issue(input logic instr, input logic [xlen-1:0] addr,
                       input logic [xlen-1:0] wdata, input logic [strb_width-1:0] wstrb);
    logic [xlen:0] resp;
    @(posedge clock);
    mem_valid_i <= 1'b1;
    mem_instr_i <= instr;
    mem_addr_i <= addr;
    mem_wdata_i <= wdata;
    mem_wstrb_i <= wstrb;
    last_mtime = cycle_count + 64'd1; // Timer steps on this same edge
    resp = predict_response(instr, addr, wdata, wstrb, last_mtime);
    exp_rdata_q.push_back(resp[xlen-1:0]);
    exp_error_q.push_back(resp[xlen]);
    exp_due_q.push_back(edge_count + 2);
  endtask

  task automatic idle();
    @(posedge clock);
    mem_valid_i <= 1'b0;
    mem_wstrb_i <= '0;
  endtask

  always @(posedge clock) begin
    edge_count <= edge_count + 1;
    if (reset) begin
      cycle_count <= cycle_count + 64'd1; // Mirrors mtime
    end
  end

  always @(negedge clock) begin
    if (reset) begin
      if (mem_ready_o) begin
        if (exp_rdata_q.size() == 0) begin
          stop_on_error("mem_ready_o went high with no request outstanding");
        end else begin
          if (exp_due_q.pop_front() != edge_count) begin
            stop_on_error("mem_ready_o did not come exactly one cycle after its request");
          end
          check_value("mem_rdata_o", mem_rdata_o, exp_rdata_q.pop_front());
          check_value("mem_error_o", 32'(mem_error_o), 32'(exp_error_q.pop_front()));
        end
      end else if (exp_due_q.size() != 0 && exp_due_q[0] <= edge_count) begin
        stop_on_error("An expected mem_ready_o never came");
      end
    end
  end

  initial begin
    #((test_cycles + margin_cycles) * 8);
    stop_on_error("Watchdog expired before the tests finished");
  end

  initial begin
    logic [xlen-1:0] addr;
    logic [63:0] cmp_before;
    logic [63:0] mtime_at_write;
    void'($urandom(32'h24a7_075a));
    $readmemh("boot_rom.hex", rom_model);
    mem_valid_i = 1'b0;
    mem_instr_i = 1'b0;
    mem_addr_i = '0;
    mem_wdata_i = '0;
    mem_wstrb_i = '0;
    msip_model = 1'b0;
    cmp_model = '1;
    cycle_count = '0;
    last_mtime = '0;
    edge_count = 0;

    wait (reset == 1'b1);
    @(negedge clock);
    check_value("mem_ready_o", 32'(mem_ready_o), 32'h0);
    check_value("mem_error_o", 32'(mem_error_o), 32'h0);
    check_value("msip_o", 32'(msip_o), 32'h0);
    check_value("mtip_o", 32'(mtip_o), 32'h0);

    // ROM data and instruction reads, back to back
    for (int i = 0; i < int'(rom_words); i++) begin
      issue(1'b0, rom_base_addr + 32'(i * 4), $urandom, '0);
    end
    for (int i = 0; i < int'(rom_words); i++) begin
      issue(1'b1, rom_base_addr + 32'(i * 4), $urandom, '0);
    end
    idle();

    // Error responses, then normal accesses right after
    issue(1'b0, rom_top_addr, '0, '0);
    issue(1'b0, clint_top_addr, $urandom, 4'hf);
    issue(1'b1, clint_addr(clint_mtime_lo_off), '0, '0);
    issue(1'b1, clint_addr(clint_msip_off), '0, '0);
    for (int i = 0; i < 4; i++) begin
      issue(1'b0, 32'h1000_0000 + ($urandom & 32'h0fff_fffc), $urandom, 4'($urandom));
    end
    issue(1'b0, rom_base_addr + 32'h8, '0, '0);
    issue(1'b0, clint_addr(clint_mtimecmp_lo_off), '0, '0);
    idle();

    // Software interrupt bit
    issue(1'b0, clint_addr(clint_msip_off), 32'hffff_ffff, 4'h1);
    idle();
    @(negedge clock);
    check_value("msip_o", 32'(msip_o), 32'(msip_model));
    issue(1'b0, clint_addr(clint_msip_off), '0, '0);
    issue(1'b0, clint_addr(clint_msip_off), 32'hffff_fffe, 4'hf);
    idle();
    @(negedge clock);
    check_value("msip_o", 32'(msip_o), 32'(msip_model));
    issue(1'b0, clint_addr(clint_msip_off), '0, '0);
    idle();

    // Byte lane writes to mtimecmp, each read back at once
    for (int i = 0; i < 6; i++) begin
      addr = clint_addr((i % 2 == 0) ? clint_mtimecmp_lo_off : clint_mtimecmp_hi_off);
      issue(1'b0, addr, $urandom, 4'($urandom));
      issue(1'b0, addr, '0, '0);
    end
    issue(1'b0, rom_base_addr + 32'hc, $urandom, 4'hf); // ROM ignores writes
    issue(1'b0, rom_base_addr + 32'hc, '0, '0);
    idle();

    // Timer reads
    issue(1'b0, clint_addr(clint_mtime_lo_off), '0, '0);
    issue(1'b0, clint_addr(clint_mtime_hi_off), '0, '0);
    idle();

    // Timer interrupt
    issue(1'b0, clint_addr(clint_mtimecmp_hi_off), '1, 4'hf);
    issue(1'b0, clint_addr(clint_mtimecmp_lo_off), '1, 4'hf);
    repeat (4) begin
      idle();
      @(negedge clock);
      check_value("mtip_o", 32'(mtip_o), 32'h0);
    end
    issue(1'b0, clint_addr(clint_mtimecmp_lo_off), 32'd5, 4'hf);
    cmp_before = cmp_model;
    issue(1'b0, clint_addr(clint_mtimecmp_hi_off), '0, 4'hf);
    mtime_at_write = last_mtime;
    idle();
    @(negedge clock);
    check_value("mtip_o", 32'(mtip_o), 32'(mtime_at_write >= cmp_before));
    @(negedge clock);
    check_value("mtip_o", 32'(mtip_o), 32'(mtime_at_write + 64'd1 >= cmp_model));

    idle();
    repeat (3) @(negedge clock);
    if (exp_rdata_q.size() != 0) begin
      stop_on_error("Responses were still outstanding at the end of the run");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

// File: boot_rom.hex
// One 32-bit ROM word per line in hex, word 0 first
00000297
02028293
30529073
020002b7
00100313
0062a023
10500073
ffdff06f
34202373
0002a023
30200073
00000013
00000013
00000013
deadbeef
c0ffee00

// File: compile.f
soc_pkg.sv
mem_bus_if.sv
bus_decoder.sv
boot_rom.sv
clint_timer.sv
soc_bus.sv
tb_clock_gen.sv
tb_soc_bus.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/100ps --top-module tb_soc_bus \
  -f compile.f -o sim_soc_bus > build.log 2>&1 &&
  ./obj_dir/sim_soc_bus > sim.log 2>&1 ||
  echo "Build or simulation returned an error: TEST FAIL" >> sim.log
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1 || exit 0
